/* logic/mdu_pkg.sv */
// shared op codes, CP0 addresses, widths and the HI/LO word type, imported by every MDU block
package mdu_pkg;

    localparam int DATA_W     = 32;
    localparam int DWORD_W    = 64;
    localparam int CP0_ADDR_W = 5;

    // implemented CP0 registers, everything else reads as zero
    localparam logic [CP0_ADDR_W-1:0] CP0_STATUS = 5'd12;
    localparam logic [CP0_ADDR_W-1:0] CP0_CAUSE  = 5'd13;
    localparam logic [CP0_ADDR_W-1:0] CP0_EPC    = 5'd14;

    typedef enum logic [4:0] {
        ALU_NOP, ALU_MFHI, ALU_MFLO, ALU_MTHI, ALU_MTLO,
        ALU_MUL, ALU_MULT, ALU_MULTU,
        ALU_MADD, ALU_MADDU, ALU_MSUB, ALU_MSUBU,
        ALU_DIV, ALU_DIVU, ALU_MFC0, ALU_MTC0,
        ALU_LB, ALU_LBU, ALU_LH, ALU_LHU, ALU_LW, ALU_LWL, ALU_LWR, ALU_LL,
        ALU_TLBR, ALU_TLBWI, ALU_TLBWR, ALU_TLBP
    } aluop_t;

    typedef enum logic [2:0] {
        TOP_NOP,
        TOP_TLBR,
        TOP_TLBWI,
        TOP_TLBWR,
        TOP_TLBP
    } tlbop_t;

    typedef struct packed {
        logic [DATA_W-1:0] hi;
        logic [DATA_W-1:0] lo;
    } hilo_pair_t;

    // the HI/LO pair is used as one 64-bit value by the accumulate ops
    // and as two halves by the moves
    typedef union packed {
        logic [DWORD_W-1:0] word;
        hilo_pair_t         half;
    } hilo_t;

endpackage

/* logic/ex_mem_if.sv */
// execute-to-memory stage register contents, driven by the execute stage and read by alu_mem
interface ex_mem_if;
    import mdu_pkg::*;

    aluop_t                aluop;
    logic [DATA_W-1:0]     alures;
    logic [DWORD_W-1:0]    mulhi;
    logic [DWORD_W-1:0]    mullo;
    logic                  mul_s;
    hilo_t                 divres;
    logic [CP0_ADDR_W-1:0] cp0sel;

    modport ex (
        output aluop, alures, mulhi, mullo, mul_s, divres, cp0sel
    );

    modport mem (
        input aluop, alures, mulhi, mullo, mul_s, divres, cp0sel
    );

endinterface

/* logic/div_iter.sv */
// radix-2 restoring divider for DIV and DIVU, started by a pulse and finishing 32 cycles later
module div_iter (
    input  logic                       clk,
    input  logic                       arst_n_i,
    input  logic                       start_i,
    input  logic                       signed_i,
    input  logic [mdu_pkg::DATA_W-1:0] dividend_i,
    input  logic [mdu_pkg::DATA_W-1:0] divisor_i,
    output logic                       busy_o,
    output logic                       done_o,
    output logic [mdu_pkg::DATA_W-1:0] quot_o,
    output logic [mdu_pkg::DATA_W-1:0] rem_o
);
    import mdu_pkg::*;

    logic              busy_q;
    logic              done_q;
    logic [4:0]        cnt_q;
    logic [DATA_W-1:0] rem_q;
    logic [DATA_W-1:0] quot_q;
    logic [DATA_W-1:0] dvsr_q;
    logic              neg_quot_q;
    logic              neg_rem_q;
    logic [DATA_W:0]   shifted;
    logic [DATA_W:0]   trial;
    logic              launch;

    assign launch  = start_i & ~busy_q;
    // quot_q starts out as the dividend and shifts its bits into the partial remainder
    assign shifted = {rem_q, quot_q[DATA_W-1]};
    assign trial   = shifted - {1'b0, dvsr_q};

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else begin
            done_q <= 1'b0;
            if (launch) begin
                busy_q <= 1'b1;
                cnt_q  <= '0;
            end else if (busy_q) begin
                cnt_q <= cnt_q + 1'b1;
                if (cnt_q == 5'd31) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    // a zero divisor makes every trial succeed, giving all-ones and the dividend back
    always_ff @(posedge clk) begin
        if (launch) begin
            rem_q      <= '0;
            quot_q     <= (signed_i && dividend_i[DATA_W-1]) ? -dividend_i : dividend_i;
            dvsr_q     <= (signed_i && divisor_i[DATA_W-1]) ? -divisor_i : divisor_i;
            neg_quot_q <= signed_i & (dividend_i[DATA_W-1] ^ divisor_i[DATA_W-1])
                          & (|divisor_i);
            neg_rem_q  <= signed_i & dividend_i[DATA_W-1];
        end else if (busy_q) begin
            if (!trial[DATA_W]) begin
                rem_q  <= trial[DATA_W-1:0];
                quot_q <= {quot_q[DATA_W-2:0], 1'b1};
            end else begin
                rem_q  <= shifted[DATA_W-1:0];
                quot_q <= {quot_q[DATA_W-2:0], 1'b0};
            end
        end
    end

    assign busy_o = busy_q;
    assign done_o = done_q;
    assign quot_o = neg_quot_q ? -quot_q : quot_q;
    assign rem_o  = neg_rem_q ? -rem_q : rem_q;

endmodule

/* logic/mdu_ex_stage.sv */
// execute stage of the MDU, forms partial products, runs the divider and fills the EX/MEM register
module mdu_ex_stage (
    input  logic                            clk,
    input  logic                            arst_n_i,
    input  logic                            valid_i,
    input  mdu_pkg::aluop_t                 aluop_i,
    input  logic [mdu_pkg::DATA_W-1:0]      a_i,
    input  logic [mdu_pkg::DATA_W-1:0]      b_i,
    input  logic [mdu_pkg::CP0_ADDR_W-1:0]  cp0sel_i,
    output logic                            busy_o,
    ex_mem_if.ex                            ex_o
);
    import mdu_pkg::*;

    logic              accept;
    logic              is_div;
    logic              is_smul;
    logic              a_neg;
    logic              b_neg;
    logic [DATA_W-1:0] a_mag;
    logic [DATA_W-1:0] b_mag;
    logic [DATA_W-1:0] pp_ll;
    logic [DATA_W-1:0] pp_lh;
    logic [DATA_W-1:0] pp_hl;
    logic [DATA_W-1:0] pp_hh;
    logic              div_busy;
    logic              div_done;
    logic [DATA_W-1:0] div_quot;
    logic [DATA_W-1:0] div_rem;
    aluop_t            div_op;

    // stay busy through the done cycle so nothing collides with the divide result
    assign busy_o = div_busy | div_done;
    assign accept = valid_i & ~busy_o;
    assign is_div = aluop_i inside {ALU_DIV, ALU_DIVU};

    assign is_smul = aluop_i inside {ALU_MUL, ALU_MULT, ALU_MADD, ALU_MSUB};
    assign a_neg   = is_smul & a_i[DATA_W-1];
    assign b_neg   = is_smul & b_i[DATA_W-1];
    assign a_mag   = a_neg ? -a_i : a_i;
    assign b_mag   = b_neg ? -b_i : b_i;

    // each 16x16 partial product keeps its full 32-bit width
    assign pp_ll = a_mag[15:0] * b_mag[15:0];
    assign pp_lh = a_mag[15:0] * b_mag[31:16];
    assign pp_hl = a_mag[31:16] * b_mag[15:0];
    assign pp_hh = a_mag[31:16] * b_mag[31:16];

    div_iter u_div (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .start_i    (accept & is_div),
        .signed_i   (aluop_i == ALU_DIV),
        .dividend_i (a_i),
        .divisor_i  (b_i),
        .busy_o     (div_busy),
        .done_o     (div_done),
        .quot_o     (div_quot),
        .rem_o      (div_rem)
    );

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_o.aluop <= ALU_NOP;
        end else if (div_done) begin
            ex_o.aluop <= div_op;
        end else if (accept && !is_div) begin
            ex_o.aluop <= aluop_i;
        end else begin
            ex_o.aluop <= ALU_NOP;
        end
    end

    // mullo packs {a_lo*b_hi, a_lo*b_lo} and mulhi packs {a_hi*b_hi, a_hi*b_lo}
    always_ff @(posedge clk) begin
        if (accept) begin
            ex_o.alures <= a_i;
            ex_o.cp0sel <= cp0sel_i;
            ex_o.mul_s  <= a_neg ^ b_neg;
            ex_o.mullo  <= {pp_lh, pp_ll};
            ex_o.mulhi  <= {pp_hh, pp_hl};
            if (is_div) begin
                div_op <= aluop_i;
            end
        end
        if (div_done) begin
            ex_o.divres.half.hi <= div_rem;
            ex_o.divres.half.lo <= div_quot;
        end
    end

endmodule

/* logic/alu_mem.sv */
// memory-stage completion, finishes products, moves HI/LO and CP0 data and decodes loads and TLB ops
module alu_mem (
    ex_mem_if.mem                            mem_i,
    input  logic                             exc_flag_i,
    input  mdu_pkg::hilo_t                   hilo_i,
    input  logic [mdu_pkg::DATA_W-1:0]       cp0_rdata_i,
    output logic [mdu_pkg::DATA_W-1:0]       result_o,
    output logic                             hilo_wen_o,
    output mdu_pkg::hilo_t                   hilo_o,
    output logic                             cp0_wen_o,
    output logic [mdu_pkg::CP0_ADDR_W-1:0]   cp0_addr_o,
    output logic [mdu_pkg::DATA_W-1:0]       cp0_wdata_o,
    output mdu_pkg::tlbop_t                  tlb_op_o,
    output logic                             load_pending_o,
    output logic                             res_valid_o
);
    import mdu_pkg::*;

    logic [DWORD_W-1:0] res_lo;
    logic [DWORD_W-1:0] res_hi;
    logic [DWORD_W-1:0] umres;
    logic [DWORD_W-1:0] smres;

    // both cross terms sit 16 bits up, the high product 32 bits up
    assign res_lo = DWORD_W'(mem_i.mullo[31:0]) + (DWORD_W'(mem_i.mullo[63:32]) << 16);
    assign res_hi = (DWORD_W'(mem_i.mulhi[31:0]) << 16) + (DWORD_W'(mem_i.mulhi[63:32]) << 32);
    assign umres  = res_lo + res_hi;
    assign smres  = mem_i.mul_s ? -umres : umres;

    assign res_valid_o = mem_i.aluop != ALU_NOP;

    always_comb begin
        hilo_wen_o  = 1'b0;
        hilo_o      = hilo_i;
        result_o    = mem_i.alures;
        cp0_wen_o   = 1'b0;
        cp0_addr_o  = '0;
        cp0_wdata_o = '0;

        case (mem_i.aluop)
            ALU_MFHI: result_o = hilo_i.half.hi;
            ALU_MFLO: result_o = hilo_i.half.lo;
            ALU_MUL:  result_o = smres[DATA_W-1:0];
            ALU_MTHI: begin
                hilo_wen_o     = 1'b1;
                hilo_o.half.hi = mem_i.alures;
            end
            ALU_MTLO: begin
                hilo_wen_o     = 1'b1;
                hilo_o.half.lo = mem_i.alures;
            end
            ALU_MULT: begin
                hilo_wen_o  = 1'b1;
                hilo_o.word = smres;
            end
            ALU_MULTU: begin
                hilo_wen_o  = 1'b1;
                hilo_o.word = umres;
            end
            ALU_MADD, ALU_MADDU: begin
                hilo_wen_o  = 1'b1;
                hilo_o.word = hilo_i.word + smres;
            end
            ALU_MSUB, ALU_MSUBU: begin
                hilo_wen_o  = 1'b1;
                hilo_o.word = hilo_i.word - smres;
            end
            ALU_DIV, ALU_DIVU: begin
                hilo_wen_o = 1'b1;
                hilo_o     = mem_i.divres;
            end
            ALU_MFC0: begin
                cp0_addr_o = mem_i.cp0sel;
                result_o   = cp0_rdata_i;
            end
            ALU_MTC0: begin
                cp0_addr_o  = mem_i.cp0sel;
                cp0_wen_o   = ~exc_flag_i;
                cp0_wdata_o = mem_i.alures;
            end
            default: ;
        endcase
    end

    // the load address passes through result_o while memory supplies the data later
    assign load_pending_o = mem_i.aluop inside {ALU_LB, ALU_LBU, ALU_LH, ALU_LHU,
                                                ALU_LW, ALU_LWL, ALU_LWR, ALU_LL};

    always_comb begin
        case (mem_i.aluop)
            ALU_TLBR:  tlb_op_o = TOP_TLBR;
            ALU_TLBWI: tlb_op_o = TOP_TLBWI;
            ALU_TLBWR: tlb_op_o = TOP_TLBWR;
            ALU_TLBP:  tlb_op_o = TOP_TLBP;
            default:   tlb_op_o = TOP_NOP;
        endcase
    end

endmodule

/* logic/mdu_state.sv */
// architectural HI/LO pair and the Status, Cause and EPC registers with their read ports
module mdu_state (
    input  logic                            clk,
    input  logic                            arst_n_i,
    input  logic                            hilo_wen_i,
    input  mdu_pkg::hilo_t                  hilo_i,
    output mdu_pkg::hilo_t                  hilo_o,
    input  logic                            cp0_wen_i,
    input  logic [mdu_pkg::CP0_ADDR_W-1:0]  cp0_addr_i,
    input  logic [mdu_pkg::DATA_W-1:0]      cp0_wdata_i,
    output logic [mdu_pkg::DATA_W-1:0]      cp0_rdata_o
);
    import mdu_pkg::*;

    hilo_t             hilo_q;
    logic [DATA_W-1:0] status_q;
    logic [DATA_W-1:0] cause_q;
    logic [DATA_W-1:0] epc_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hilo_q   <= '0;
            status_q <= '0;
            cause_q  <= '0;
            epc_q    <= '0;
        end else begin
            if (hilo_wen_i) begin
                hilo_q <= hilo_i;
            end
            if (cp0_wen_i) begin
                case (cp0_addr_i)
                    CP0_STATUS: status_q <= cp0_wdata_i;
                    CP0_CAUSE:  cause_q  <= cp0_wdata_i;
                    CP0_EPC:    epc_q    <= cp0_wdata_i;
                    default: ;
                endcase
            end
        end
    end

    assign hilo_o = hilo_q;

    always_comb begin
        case (cp0_addr_i)
            CP0_STATUS: cp0_rdata_o = status_q;
            CP0_CAUSE:  cp0_rdata_o = cause_q;
            CP0_EPC:    cp0_rdata_o = epc_q;
            default:    cp0_rdata_o = '0;
        endcase
    end

endmodule

/* logic/mdu_top.sv */
// top level of the multiply/divide and HI/LO completion path, wires execute, memory and state
module mdu_top (
    input  logic                            clk,
    input  logic                            arst_n_i,
    input  logic                            valid_i,
    input  mdu_pkg::aluop_t                 aluop_i,
    input  logic [mdu_pkg::DATA_W-1:0]      a_i,
    input  logic [mdu_pkg::DATA_W-1:0]      b_i,
    input  logic [mdu_pkg::CP0_ADDR_W-1:0]  cp0sel_i,
    input  logic                            exc_flag_i,
    output logic                            busy_o,
    output logic                            res_valid_o,
    output logic [mdu_pkg::DATA_W-1:0]      result_o,
    output logic                            load_pending_o,
    output mdu_pkg::tlbop_t                 tlb_op_o
);
    import mdu_pkg::*;

    logic                  hilo_wen;
    hilo_t                 hilo_wdata;
    hilo_t                 hilo_rdata;
    logic                  cp0_wen;
    logic [CP0_ADDR_W-1:0] cp0_addr;
    logic [DATA_W-1:0]     cp0_wdata;
    logic [DATA_W-1:0]     cp0_rdata;

    ex_mem_if ex_mem ();

    mdu_ex_stage u_ex (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .valid_i  (valid_i),
        .aluop_i  (aluop_i),
        .a_i      (a_i),
        .b_i      (b_i),
        .cp0sel_i (cp0sel_i),
        .busy_o   (busy_o),
        .ex_o     (ex_mem.ex)
    );

    alu_mem u_mem (
        .mem_i          (ex_mem.mem),
        .exc_flag_i     (exc_flag_i),
        .hilo_i         (hilo_rdata),
        .cp0_rdata_i    (cp0_rdata),
        .result_o       (result_o),
        .hilo_wen_o     (hilo_wen),
        .hilo_o         (hilo_wdata),
        .cp0_wen_o      (cp0_wen),
        .cp0_addr_o     (cp0_addr),
        .cp0_wdata_o    (cp0_wdata),
        .tlb_op_o       (tlb_op_o),
        .load_pending_o (load_pending_o),
        .res_valid_o    (res_valid_o)
    );

    mdu_state u_state (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .hilo_wen_i  (hilo_wen),
        .hilo_i      (hilo_wdata),
        .hilo_o      (hilo_rdata),
        .cp0_wen_i   (cp0_wen),
        .cp0_addr_i  (cp0_addr),
        .cp0_wdata_i (cp0_wdata),
        .cp0_rdata_o (cp0_rdata)
    );

endmodule

/* bench/mdu_chk.sv */
// protocol assertions on the mdu_top outputs, attached to every mdu_top instance by bind
module mdu_chk (
    input logic            clk,
    input logic            arst_n_i,
    input logic            busy_i,
    input logic            res_valid_i,
    input logic            load_pending_i,
    input mdu_pkg::tlbop_t tlb_op_i
);
    import mdu_pkg::*;

    // number of assertion failures so far, read by the testbench
    int assert_fails = 0;

    // the stage register holds NOP for the whole divide
    assert property (@(posedge clk) disable iff (!arst_n_i) busy_i |-> !res_valid_i)
        else begin
            $error("result marked valid while the divider is busy");
            assert_fails++;
        end

    assert property (@(posedge clk) disable iff (!arst_n_i) !res_valid_i |-> tlb_op_i == TOP_NOP)
        else begin
            $error("TLB op driven without a valid result");
            assert_fails++;
        end

    assert property (@(posedge clk) disable iff (!arst_n_i) load_pending_i |-> res_valid_i)
        else begin
            $error("load flag raised without a valid result");
            assert_fails++;
        end

endmodule

bind mdu_top mdu_chk u_chk (
    .clk            (clk),
    .arst_n_i       (arst_n_i),
    .busy_i         (busy_o),
    .res_valid_i    (res_valid_o),
    .load_pending_i (load_pending_o),
    .tlb_op_i       (tlb_op_o)
);

/* bench/mdu_tb.sv */
// directed testbench for mdu_top, issues each op class and checks the results against a reference model
module mdu_tb;
    import mdu_pkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int OP_CYCLES    = 40;

    logic                  clk;
    logic                  arst_n_i;
    logic                  valid_i;
    aluop_t                aluop_i;
    logic [DATA_W-1:0]     a_i;
    logic [DATA_W-1:0]     b_i;
    logic [CP0_ADDR_W-1:0] cp0sel_i;
    logic                  exc_flag_i;
    logic                  busy_o;
    logic                  res_valid_o;
    logic [DATA_W-1:0]     result_o;
    logic                  load_pending_o;
    tlbop_t                tlb_op_o;

    // reference copy of the architectural state
    hilo_t             ref_hilo;
    logic [DATA_W-1:0] ref_cp0 [32];
    logic [31:0]       rng_state;
    int                cycle_cnt  = 0;
    int                ops_issued = 0;

    mdu_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic logic [DWORD_W-1:0] signed_product(input logic [DATA_W-1:0] a,
                                                          input logic [DATA_W-1:0] b);
        logic signed [DWORD_W-1:0] sa;
        logic signed [DWORD_W-1:0] sb;
        sa = $signed(a);
        sb = $signed(b);
        return sa * sb;
    endfunction

    function automatic logic [DWORD_W-1:0] unsigned_product(input logic [DATA_W-1:0] a,
                                                            input logic [DATA_W-1:0] b);
        return DWORD_W'(a) * DWORD_W'(b);
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_word(input string what, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch at %0t: %s gave %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_tlb(input string what, input tlbop_t got, input tlbop_t exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch at %0t: %s gave %s, expected %s",
                               $time, what, got.name(), exp.name()));
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    // one-cycle strobe, accepted at the second edge since busy_o is low between tests
    task automatic issue(input aluop_t op, input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b,
                         input logic [CP0_ADDR_W-1:0] sel, input logic exc);
        @(posedge clk);
        valid_i    <= 1'b1;
        aluop_i    <= op;
        a_i        <= a;
        b_i        <= b;
        cp0sel_i   <= sel;
        exc_flag_i <= exc;
        ops_issued++;
        @(posedge clk);
        valid_i <= 1'b0;
    endtask

    // issues an op, waits for its result and checks the load flag and TLB decode
    task automatic run_op(input aluop_t op, input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b,
                          input logic [CP0_ADDR_W-1:0] sel, input logic exc);
        logic   is_load;
        tlbop_t exp_tlb;
        is_load = op inside {ALU_LB, ALU_LBU, ALU_LH, ALU_LHU, ALU_LW, ALU_LWL, ALU_LWR, ALU_LL};
        case (op)
            ALU_TLBR:  exp_tlb = TOP_TLBR;
            ALU_TLBWI: exp_tlb = TOP_TLBWI;
            ALU_TLBWR: exp_tlb = TOP_TLBWR;
            ALU_TLBP:  exp_tlb = TOP_TLBP;
            default:   exp_tlb = TOP_NOP;
        endcase
        issue(op, a, b, sel, exc);
        @(negedge clk);
        while (res_valid_o !== 1'b1) begin
            @(negedge clk);
        end
        check_flag({op.name(), " load flag"}, load_pending_o, is_load);
        check_tlb({op.name(), " tlb op"}, tlb_op_o, exp_tlb);
        if (is_load) begin
            check_word({op.name(), " address"}, result_o, a);
        end
    endtask

    task automatic check_hilo(input string what);
        run_op(ALU_MFHI, '0, '0, '0, 1'b0);
        check_word({what, " HI"}, result_o, ref_hilo.half.hi);
        run_op(ALU_MFLO, '0, '0, '0, 1'b0);
        check_word({what, " LO"}, result_o, ref_hilo.half.lo);
    endtask

    task automatic write_hilo(input logic [DATA_W-1:0] hi, input logic [DATA_W-1:0] lo);
        run_op(ALU_MTHI, hi, '0, '0, 1'b0);
        ref_hilo.half.hi = hi;
        run_op(ALU_MTLO, lo, '0, '0, 1'b0);
        ref_hilo.half.lo = lo;
    endtask

    task automatic mtc0(input logic [CP0_ADDR_W-1:0] sel, input logic [DATA_W-1:0] v,
                        input logic exc);
        run_op(ALU_MTC0, v, '0, sel, exc);
        if (!exc && (sel inside {CP0_STATUS, CP0_CAUSE, CP0_EPC})) begin
            ref_cp0[sel] = v;
        end
    endtask

    task automatic reset_state();
        @(negedge clk);
        check_flag("res_valid_o after reset", res_valid_o, 1'b0);
        check_flag("busy_o after reset", busy_o, 1'b0);
        check_flag("load_pending_o after reset", load_pending_o, 1'b0);
        check_tlb("tlb_op_o after reset", tlb_op_o, TOP_NOP);
        check_hilo("reset");
    endtask

    task automatic hilo_moves();
        logic [DATA_W-1:0] v;
        write_hilo(next_rand(), next_rand());
        check_hilo("MTHI and MTLO");
        v = next_rand();
        run_op(ALU_MTHI, v, '0, '0, 1'b0);
        ref_hilo.half.hi = v;
        check_hilo("MTHI alone");
        v = next_rand();
        run_op(ALU_MTLO, v, '0, '0, 1'b0);
        ref_hilo.half.lo = v;
        check_hilo("MTLO alone");
    endtask

    task automatic multiplies();
        logic [DATA_W-1:0]  a;
        logic [DATA_W-1:0]  b;
        logic [DWORD_W-1:0] p;
        for (int i = 0; i < 6; i++) begin
            a = next_rand();
            b = next_rand();
            // first pass negative times positive, second negative times negative
            a[DATA_W-1] = (i < 2) ? 1'b1 : a[DATA_W-1];
            b[DATA_W-1] = (i < 2) ? (i == 1) : b[DATA_W-1];
            p = signed_product(a, b);
            run_op(ALU_MUL, a, b, '0, 1'b0);
            check_word("MUL", result_o, p[DATA_W-1:0]);
            run_op(ALU_MULT, a, b, '0, 1'b0);
            ref_hilo.word = p;
            check_hilo("MULT");
            run_op(ALU_MULTU, a, b, '0, 1'b0);
            ref_hilo.word = unsigned_product(a, b);
            check_hilo("MULTU");
        end
    endtask

    task automatic accumulates();
        aluop_t            ops [4] = '{ALU_MADD, ALU_MADDU, ALU_MSUB, ALU_MSUBU};
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        for (int round = 0; round < 2; round++) begin
            foreach (ops[i]) begin
                a = next_rand();
                b = next_rand();
                a[DATA_W-1] = (round == 0) ? 1'b1 : a[DATA_W-1];
                write_hilo(next_rand(), next_rand());
                run_op(ops[i], a, b, '0, 1'b0);
                case (ops[i])
                    ALU_MADD:  ref_hilo.word = ref_hilo.word + signed_product(a, b);
                    ALU_MADDU: ref_hilo.word = ref_hilo.word + unsigned_product(a, b);
                    ALU_MSUB:  ref_hilo.word = ref_hilo.word - signed_product(a, b);
                    default:   ref_hilo.word = ref_hilo.word - unsigned_product(a, b);
                endcase
                check_hilo(ops[i].name());
            end
        end
    endtask

    task automatic run_div(input logic sgn, input logic [DATA_W-1:0] a,
                           input logic [DATA_W-1:0] b);
        aluop_t            op;
        logic [DATA_W-1:0] a_mag;
        logic [DATA_W-1:0] b_mag;
        logic [DATA_W-1:0] q;
        logic [DATA_W-1:0] r;
        op    = sgn ? ALU_DIV : ALU_DIVU;
        a_mag = (sgn && a[DATA_W-1]) ? -a : a;
        b_mag = (sgn && b[DATA_W-1]) ? -b : b;
        if (b == '0) begin
            q = '1;
            r = a;
        end else begin
            q = a_mag / b_mag;
            r = a_mag % b_mag;
            q = (sgn && (a[DATA_W-1] ^ b[DATA_W-1])) ? -q : q;
            r = (sgn && a[DATA_W-1]) ? -r : r;
        end
        issue(op, a, b, '0, 1'b0);
        @(negedge clk);
        while (res_valid_o !== 1'b1) begin
            check_flag({op.name(), " busy while running"}, busy_o, 1'b1);
            @(negedge clk);
        end
        check_flag({op.name(), " busy at result"}, busy_o, 1'b0);
        ref_hilo.half.lo = q;
        ref_hilo.half.hi = r;
        check_hilo(op.name());
    endtask

    task automatic divides();
        run_div(1'b0, 32'd100, 32'd7);
        run_div(1'b1, -32'sd100, 32'd7);
        run_div(1'b1, 32'd100, -32'sd7);
        run_div(1'b1, -32'sd100, -32'sd7);
        run_div(1'b0, next_rand(), next_rand() >> 8);
        run_div(1'b1, next_rand(), next_rand() >> 12);
        run_div(1'b1, -32'sd1234, 32'd0);
        run_div(1'b0, 32'hdeadbeef, 32'd0);
    endtask

    task automatic cp0_access();
        logic [CP0_ADDR_W-1:0] regs [3] = '{CP0_STATUS, CP0_CAUSE, CP0_EPC};
        logic [DATA_W-1:0]     v;
        foreach (regs[i]) begin
            v = next_rand();
            mtc0(regs[i], v, 1'b0);
            run_op(ALU_MFC0, '0, '0, regs[i], 1'b0);
            check_word("MFC0 after MTC0", result_o, ref_cp0[regs[i]]);
            mtc0(regs[i], ~v, 1'b1);
            run_op(ALU_MFC0, '0, '0, regs[i], 1'b0);
            check_word("MFC0 after blocked MTC0", result_o, ref_cp0[regs[i]]);
        end
        mtc0(5'd9, next_rand(), 1'b0);
        run_op(ALU_MFC0, '0, '0, 5'd9, 1'b0);
        check_word("MFC0 from unimplemented register", result_o, ref_cp0[9]);
    endtask

    task automatic decodes();
        aluop_t ops [12] = '{ALU_LB, ALU_LBU, ALU_LH, ALU_LHU, ALU_LW, ALU_LWL, ALU_LWR, ALU_LL,
                             ALU_TLBR, ALU_TLBWI, ALU_TLBWR, ALU_TLBP};
        foreach (ops[i]) begin
            run_op(ops[i], next_rand(), next_rand(), '0, 1'b0);
        end
    endtask

    // every issued op gets its own share of the cycle budget
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (UUT.u_chk.assert_fails != 0) begin
            fail_run("a protocol assertion on the DUT outputs failed");
        end else if (cycle_cnt > RESET_CYCLES + OP_CYCLES * (ops_issued + 1)) begin
            fail_run($sformatf("timeout, the DUT gave no result within %0d cycles", cycle_cnt));
        end
    end

    initial begin
        arst_n_i   = 1'b0;
        valid_i    = 1'b0;
        aluop_i    = ALU_NOP;
        a_i        = '0;
        b_i        = '0;
        cp0sel_i   = '0;
        exc_flag_i = 1'b0;
        ref_hilo   = '0;
        rng_state  = 32'd44;
        foreach (ref_cp0[i]) begin
            ref_cp0[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n_i <= 1'b1;
        reset_state();
        hilo_moves();
        multiplies();
        accumulates();
        divides();
        cp0_access();
        decodes();
        @(negedge clk);
        if (UUT.u_chk.assert_fails != 0) begin
            fail_run("a protocol assertion on the DUT outputs failed");
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

/* files.f */
logic/mdu_pkg.sv
logic/ex_mem_if.sv
logic/div_iter.sv
logic/mdu_ex_stage.sv
logic/alu_mem.sv
logic/mdu_state.sv
logic/mdu_top.sv
bench/mdu_chk.sv
bench/mdu_tb.sv

/* Bender.yml */
package:
  name: mdu

sources:
  - logic/mdu_pkg.sv
  - logic/ex_mem_if.sv
  - logic/div_iter.sv
  - logic/mdu_ex_stage.sv
  - logic/alu_mem.sv
  - logic/mdu_state.sv
  - logic/mdu_top.sv
  - target: test
    files:
      - bench/mdu_chk.sv
      - bench/mdu_tb.sv
